/* build.f */
logic/icache_pkg.sv
logic/icache_data_array.sv
logic/icache_tag_array.sv
logic/icache_ctrl.sv
logic/icache_cfg_regs.sv
logic/icache_top.sv
sim/icache_tb.sv

/* run_sim.sh */
#!/bin/bash
# builds the instruction cache testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module icache_tb -f build.f -o icache_sim
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/icache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation did not run to completion"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

/* sim/icache_tb.sv */
module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import icache_pkg::*;

    localparam int RANDOM_FETCHES = 400;
    localparam int FETCH_BUDGET   = 1000;
    localparam int CYCLE_LIMIT    = FETCH_BUDGET * 16 + 4000;
    localparam int MISS_WAIT_MAX  = 12;
    localparam logic [TAG_BITS-1:0] TAG_SET [4] = '{20'h00000, 20'h00001, 20'h5A5A5, 20'hFFFFF};

    logic       clk;
    logic       nrst;
    fetch_req_t fetch_req;
    fetch_rsp_t fetch_rsp;
    logic       fetch_busy;
    l2_req_t    l2_req;
    l2_rsp_t    l2_rsp;
    csr_req_t   csr_req;
    csr_rsp_t   csr_rsp;

    logic [31:0] lfsr_state;
    int          error_count;
    int          cycle_count;
    int          l2_delay;
    int          l2_rsp_cycle;

    // reference copy of the tag array and the event counters
    logic [NUM_LINES-1:0] model_valid;
    logic [TAG_BITS-1:0]  model_tag [NUM_LINES];
    int                   model_hits;
    int                   model_misses;
    logic [31:0]          expected_q [$];

    icache_top DUT (
        .clk        (clk),
        .nrst       (nrst),
        .fetch_req  (fetch_req),
        .l2_rsp     (l2_rsp),
        .csr_req    (csr_req),
        .fetch_rsp  (fetch_rsp),
        .fetch_busy (fetch_busy),
        .l2_req     (l2_req),
        .csr_rsp    (csr_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // helpers
    // --------------------

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            error_count++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // word w of a line is its own byte address scrambled by a constant
    function automatic logic [31:0] l2_word(input logic [TAG_BITS+INDEX_BITS-1:0] line_addr,
                                            input logic [3:0] w);
        return {line_addr, w, 2'b00} ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic [LINE_BITS-1:0] make_line(
        input logic [TAG_BITS+INDEX_BITS-1:0] line_addr);
        logic [LINE_BITS-1:0] bits;
        for (int w = 0; w < WORDS_PER_LINE; w++)
            bits[w*32 +: 32] = l2_word(line_addr, 4'(w));
        return bits;
    endfunction

    // few tags and sixteen indices, so lines come back often
    function automatic icache_addr_t random_addr();
        icache_addr_t a;
        a.tag    = TAG_SET[2'(take_bits(2))];
        a.index  = 6'(take_bits(4));
        a.offset = {4'(take_bits(4)), 2'b00};
        return a;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
            check_value("fetch_rsp.valid", 64'(fetch_rsp.valid), 64'd0);
            check_value("l2_req.valid", 64'(l2_req.valid), 64'd0);
            check_value("fetch_busy", 64'(fetch_busy), 64'd0);
        end
    endtask

    // --------------------
    // fetch sequence
    // --------------------

    task automatic do_fetch(input icache_addr_t a);
        logic        hit;
        logic [31:0] exp_word;
        int          waited;
        hit = model_valid[a.index] && (model_tag[a.index] == a.tag);
        expected_q.push_back(l2_word({a.tag, a.index}, a.offset[5:2]));
        fetch_req = '{valid: 1'b1, addr: a};
        if (!hit)
            l2_delay = 1 + int'(take_bits(3));
        @(posedge clk);
        #1;
        fetch_req.valid = 1'b0;
        if (hit)
        begin
            model_hits++;
            check_value("fetch_rsp.valid", 64'(fetch_rsp.valid), 64'd1);
            check_value("fetch_busy", 64'(fetch_busy), 64'd0);
            check_value("l2_req.valid", 64'(l2_req.valid), 64'd0);
        end
        else
        begin
            model_misses++;
            model_valid[a.index] = 1'b1;
            model_tag[a.index]   = a.tag;
            check_value("l2_req.valid", 64'(l2_req.valid), 64'd1);
            check_value("l2_req.line_addr", 64'(l2_req.line_addr), 64'({a.tag, a.index}));
            waited = 0;
            while (!fetch_rsp.valid && waited < MISS_WAIT_MAX)
            begin
                check_value("fetch_busy", 64'(fetch_busy), 64'd1);
                @(posedge clk);
                #1;
                waited++;
                check_value("l2_req.valid", 64'(l2_req.valid), 64'd0);
            end
            if (!fetch_rsp.valid)
            begin
                error_count++;
                $display("a miss at %0t ns got no response from the cache", $time);
            end
            else
            begin
                check_value("cycles from l2_rsp to fetch_rsp",
                            64'(cycle_count - l2_rsp_cycle), 64'd2);
                check_value("fetch_busy", 64'(fetch_busy), 64'd0);
            end
        end
        exp_word = expected_q.pop_front();
        if (fetch_rsp.valid)
            check_value("fetch_rsp.data", 64'(fetch_rsp.data), 64'(exp_word));
    endtask

    task automatic random_fetches(input int n);
        repeat (n)
        begin
            do_fetch(random_addr());
            if (take_bits(3) == 0)
                idle_cycles(1 + int'(take_bits(2)));
        end
    endtask

    // --------------------
    // configuration access
    // --------------------

    task automatic csr_write(input logic [1:0] addr, input logic [31:0] data);
        csr_req = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
        @(posedge clk);
        #1;
        csr_req = '0;
        check_value("csr_rsp.valid", 64'(csr_rsp.valid), 64'd0);
    endtask

    task automatic csr_read_check(input logic [1:0] addr, input logic [31:0] exp,
                                  input string what);
        csr_req = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: 32'd0};
        @(posedge clk);
        #1;
        csr_req = '0;
        check_value("csr_rsp.valid", 64'(csr_rsp.valid), 64'd1);
        check_value({"csr_rsp.rdata of ", what}, 64'(csr_rsp.rdata), 64'(exp));
    endtask

    // --------------------
    // level-2 model
    // --------------------

    // each miss is answered after the delay drawn when its fetch was issued
    initial
    begin
        logic [TAG_BITS+INDEX_BITS-1:0] line_addr;
        l2_rsp       = '0;
        l2_rsp_cycle = 0;
        forever
        begin
            @(posedge clk);
            #1;
            if (l2_req.valid)
            begin
                line_addr = l2_req.line_addr;
                repeat (l2_delay) @(posedge clk);
                #1;
                l2_rsp       = '{valid: 1'b1, line: make_line(line_addr)};
                l2_rsp_cycle = cycle_count;
                @(posedge clk);
                #1;
                l2_rsp.valid = 1'b0;
            end
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Errors found");
        $finish;
    end

    // --------------------
    // test sequence
    // --------------------

    initial
    begin
        logic [NUM_LINES-1:0] saved_valid;
        logic [TAG_BITS-1:0]  saved_tag [NUM_LINES];
        icache_addr_t         a;

        nrst         = 1'b0;
        fetch_req    = '0;
        csr_req      = '0;
        lfsr_state   = 32'd32260;
        error_count  = 0;
        l2_delay     = 1;
        model_valid  = '0;
        model_hits   = 0;
        model_misses = 0;
        repeat (5) @(posedge clk);
        #1;
        nrst = 1'b1;
        idle_cycles(2);

        // one line is filled, then all of its words hit back to back
        a = '{tag: TAG_SET[1], index: 6'd5, offset: 6'd0};
        do_fetch(a);
        for (int w = 0; w < WORDS_PER_LINE; w++)
        begin
            a.offset = {4'(w), 2'b00};
            do_fetch(a);
        end

        random_fetches(RANDOM_FETCHES);
        csr_read_check(CSR_HITS, 32'(model_hits), "CSR_HITS");
        csr_read_check(CSR_MISSES, 32'(model_misses), "CSR_MISSES");
        csr_read_check(CSR_CTRL, 32'd0, "CSR_CTRL");
        csr_read_check(2'd3, 32'd0, "address 3");

        // every line cached before the invalidate must miss once
        saved_valid = model_valid;
        saved_tag   = model_tag;
        csr_write(CSR_CTRL, 32'd1);
        model_valid = '0;
        for (int i = 0; i < NUM_LINES; i++)
        begin
            if (saved_valid[i])
            begin
                a = '{tag: saved_tag[i], index: 6'(i), offset: {4'(take_bits(4)), 2'b00}};
                do_fetch(a);
            end
        end
        csr_read_check(CSR_MISSES, 32'(model_misses), "CSR_MISSES");

        csr_write(CSR_HITS, 32'd0);
        csr_write(CSR_MISSES, 32'd0);
        model_hits   = 0;
        model_misses = 0;
        csr_read_check(CSR_HITS, 32'd0, "CSR_HITS");
        csr_read_check(CSR_MISSES, 32'd0, "CSR_MISSES");

        random_fetches(RANDOM_FETCHES);
        csr_read_check(CSR_HITS, 32'(model_hits), "CSR_HITS");
        csr_read_check(CSR_MISSES, 32'(model_misses), "CSR_MISSES");
        idle_cycles(4);

        $display("run complete after %0d cycles with %0d errors", cycle_count, error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* logic/icache_top.sv */
module icache_top (
    input  logic                    clk,
    input  logic                    nrst,
    input  icache_pkg::fetch_req_t  fetch_req,
    input  icache_pkg::l2_rsp_t     l2_rsp,
    input  icache_pkg::csr_req_t    csr_req,
    output icache_pkg::fetch_rsp_t  fetch_rsp,
    output logic                    fetch_busy,
    output icache_pkg::l2_req_t     l2_req,
    output icache_pkg::csr_rsp_t    csr_rsp
);
    import icache_pkg::*;

    logic [INDEX_BITS-1:0] lookup_index;
    logic [TAG_BITS-1:0]   lookup_tag;
    logic                  lookup_hit;
    logic [INDEX_BITS-1:0] rd_index;
    logic [3:0]            rd_word;
    logic [31:0]           rd_data;
    logic                  refill;
    logic [INDEX_BITS-1:0] refill_index;
    logic [TAG_BITS-1:0]   refill_tag;
    logic                  rsp_valid;
    logic                  hit_event;
    logic                  miss_event;
    logic                  invalidate_all;

    icache_ctrl u_ctrl (
        .clk             (clk),
        .nrst            (nrst),
        .fetch_req       (fetch_req),
        .lookup_hit      (lookup_hit),
        .l2_rsp_valid    (l2_rsp.valid),
        .lookup_index    (lookup_index),
        .lookup_tag      (lookup_tag),
        .rd_index        (rd_index),
        .rd_word         (rd_word),
        .refill          (refill),
        .refill_index    (refill_index),
        .refill_tag      (refill_tag),
        .fetch_rsp_valid (rsp_valid),
        .fetch_busy      (fetch_busy),
        .l2_req          (l2_req),
        .hit_event       (hit_event),
        .miss_event      (miss_event)
    );

    icache_tag_array u_tag_array (
        .clk            (clk),
        .nrst           (nrst),
        .lookup_index   (lookup_index),
        .lookup_tag     (lookup_tag),
        .refill         (refill),
        .refill_index   (refill_index),
        .refill_tag     (refill_tag),
        .invalidate_all (invalidate_all),
        .lookup_hit     (lookup_hit)
    );

    // the refill line comes straight from level 2
    icache_data_array u_data_array (
        .clk          (clk),
        .nrst         (nrst),
        .rd_index     (rd_index),
        .rd_word      (rd_word),
        .refill       (refill),
        .refill_index (refill_index),
        .refill_line  (l2_rsp.line),
        .rd_data      (rd_data)
    );

    icache_cfg_regs u_cfg_regs (
        .clk            (clk),
        .nrst           (nrst),
        .csr_req        (csr_req),
        .hit_event      (hit_event),
        .miss_event     (miss_event),
        .csr_rsp        (csr_rsp),
        .invalidate_all (invalidate_all)
    );

    assign fetch_rsp = '{valid: rsp_valid, data: rd_data};

endmodule

/* logic/icache_cfg_regs.sv */
module icache_cfg_regs (
    input  logic                    clk,
    input  logic                    nrst,
    input  icache_pkg::csr_req_t    csr_req,
    input  logic                    hit_event,
    input  logic                    miss_event,
    output icache_pkg::csr_rsp_t    csr_rsp,
    output logic                    invalidate_all
);
    import icache_pkg::*;

    logic [31:0] hits_q;
    logic [31:0] misses_q;
    logic        rsp_valid_q;
    logic [31:0] rdata_q;
    logic [31:0] rdata_d;

    // --------------------
    // control register
    // --------------------

    // the command acts at the edge that ends the write, nothing is stored
    assign invalidate_all = csr_req.wr && (csr_req.addr == CSR_CTRL) && csr_req.wdata[0];

    // --------------------
    // event counters
    // --------------------

    // a clearing write wins over an event in the same cycle
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            hits_q   <= '0;
            misses_q <= '0;
        end
        else
        begin
            if (csr_req.wr && (csr_req.addr == CSR_HITS))
                hits_q <= '0;
            else if (hit_event)
                hits_q <= hits_q + 32'd1;

            if (csr_req.wr && (csr_req.addr == CSR_MISSES))
                misses_q <= '0;
            else if (miss_event)
                misses_q <= misses_q + 32'd1;
        end
    end

    // --------------------
    // read back
    // --------------------

    always_comb
    begin
        case (csr_req.addr)
            CSR_HITS:   rdata_d = hits_q;
            CSR_MISSES: rdata_d = misses_q;
            default:    rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            rsp_valid_q <= 1'b0;
        else
            rsp_valid_q <= csr_req.rd;
    end

    always_ff @(posedge clk)
    begin
        rdata_q <= rdata_d;
    end

    assign csr_rsp = '{valid: rsp_valid_q, rdata: rdata_q};

endmodule

/* logic/icache_ctrl.sv */
module icache_ctrl (
    input  logic                                clk,
    input  logic                                nrst,
    input  icache_pkg::fetch_req_t              fetch_req,
    input  logic                                lookup_hit,
    input  logic                                l2_rsp_valid,
    output logic [icache_pkg::INDEX_BITS-1:0]   lookup_index,
    output logic [icache_pkg::TAG_BITS-1:0]     lookup_tag,
    output logic [icache_pkg::INDEX_BITS-1:0]   rd_index,
    output logic [3:0]                          rd_word,
    output logic                                refill,
    output logic [icache_pkg::INDEX_BITS-1:0]   refill_index,
    output logic [icache_pkg::TAG_BITS-1:0]     refill_tag,
    output logic                                fetch_rsp_valid,
    output logic                                fetch_busy,
    output icache_pkg::l2_req_t                 l2_req,
    output logic                                hit_event,
    output logic                                miss_event
);
    import icache_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_REREAD
    } state_t;

    state_t       state_q;
    state_t       state_d;
    icache_addr_t miss_addr_q;
    logic         l2_valid_q;
    logic         accept;

    // --------------------
    // lookup and events
    // --------------------

    // requests are only taken in idle, anything strobed while busy is dropped
    assign lookup_index = fetch_req.addr.index;
    assign lookup_tag   = fetch_req.addr.tag;
    assign accept       = (state_q == ST_IDLE) && fetch_req.valid;
    assign hit_event    = accept && lookup_hit;
    assign miss_event   = accept && !lookup_hit;

    // --------------------
    // array control
    // --------------------

    assign refill       = (state_q == ST_WAIT) && l2_rsp_valid;
    assign refill_index = miss_addr_q.index;
    assign refill_tag   = miss_addr_q.tag;

    always_comb
    begin
        if (state_q == ST_REREAD)
        begin
            rd_index = miss_addr_q.index;
            rd_word  = miss_addr_q.offset[OFFSET_BITS-1:2];
        end
        else
        begin
            rd_index = fetch_req.addr.index;
            rd_word  = fetch_req.addr.offset[OFFSET_BITS-1:2];
        end
    end

    assign l2_req = '{valid: l2_valid_q, line_addr: {miss_addr_q.tag, miss_addr_q.index}};

    // --------------------
    // sequencer
    // --------------------

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:   if (miss_event) state_d = ST_WAIT;
            ST_WAIT:   if (l2_rsp_valid) state_d = ST_REREAD;
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state_q         <= ST_IDLE;
            fetch_busy      <= 1'b0;
            l2_valid_q      <= 1'b0;
            fetch_rsp_valid <= 1'b0;
        end
        else
        begin
            state_q         <= state_d;
            fetch_busy      <= (state_d != ST_IDLE);
            l2_valid_q      <= miss_event;
            fetch_rsp_valid <= hit_event || (state_q == ST_REREAD);
        end
    end

    always_ff @(posedge clk)
    begin
        if (miss_event)
        begin
            miss_addr_q <= fetch_req.addr;
        end
    end

endmodule

/* logic/icache_tag_array.sv */
module icache_tag_array (
    input  logic                                clk,
    input  logic                                nrst,
    input  logic [icache_pkg::INDEX_BITS-1:0]   lookup_index,
    input  logic [icache_pkg::TAG_BITS-1:0]     lookup_tag,
    input  logic                                refill,
    input  logic [icache_pkg::INDEX_BITS-1:0]   refill_index,
    input  logic [icache_pkg::TAG_BITS-1:0]     refill_tag,
    input  logic                                invalidate_all,
    output logic                                lookup_hit
);
    import icache_pkg::*;

    logic [TAG_BITS-1:0]  tags [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;

    // --------------------
    // lookup
    // --------------------

    assign lookup_hit = valid_q[lookup_index] && (tags[lookup_index] == lookup_tag);

    // --------------------
    // tag storage
    // --------------------

    always_ff @(posedge clk)
    begin
        if (refill)
        begin
            tags[refill_index] <= refill_tag;
        end
    end

    // --------------------
    // valid bits
    // --------------------

    // a refill in the same cycle as invalidate keeps its own line valid
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid_q <= '0;
        end
        else
        begin
            if (invalidate_all)
            begin
                valid_q <= '0;
            end
            if (refill)
            begin
                valid_q[refill_index] <= 1'b1;
            end
        end
    end

endmodule

/* logic/icache_data_array.sv */
module icache_data_array (
    input  logic                                clk,
    input  logic                                nrst,
    input  logic [icache_pkg::INDEX_BITS-1:0]   rd_index,
    input  logic [3:0]                          rd_word,
    input  logic                                refill,
    input  logic [icache_pkg::INDEX_BITS-1:0]   refill_index,
    input  logic [icache_pkg::LINE_BITS-1:0]    refill_line,
    output logic [31:0]                         rd_data
);
    import icache_pkg::*;

    // each line is kept as sixteen words so a read is a plain word select
    logic [WORDS_PER_LINE-1:0][31:0] lines [NUM_LINES];

    // --------------------
    // line storage
    // --------------------

    always_ff @(posedge clk)
    begin
        if (refill)
        begin
            lines[refill_index] <= refill_line;
        end
    end

    // --------------------
    // word read
    // --------------------

    // the read sees the old line if a refill to the same index lands on this edge
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            rd_data <= '0;
        end
        else
        begin
            rd_data <= lines[rd_index][rd_word];
        end
    end

endmodule

/* logic/icache_pkg.sv */
package icache_pkg;

    // --------------------
    // cache geometry
    // --------------------

    localparam int NUM_LINES      = 64;
    localparam int INDEX_BITS     = 6;
    localparam int OFFSET_BITS    = 6;
    localparam int TAG_BITS       = 20;
    localparam int LINE_BITS      = 512;
    localparam int WORDS_PER_LINE = 16;

    // --------------------
    // configuration register map
    // --------------------

    localparam logic [1:0] CSR_CTRL   = 2'd0;
    localparam logic [1:0] CSR_HITS   = 2'd1;
    localparam logic [1:0] CSR_MISSES = 2'd2;

    // --------------------
    // port bundles
    // --------------------

    // the upper four offset bits pick the word inside the line
    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [OFFSET_BITS-1:0] offset;
    } icache_addr_t;

    typedef struct packed {
        logic         valid;
        icache_addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } fetch_rsp_t;

    // line address is the tag followed by the index
    typedef struct packed {
        logic                           valid;
        logic [TAG_BITS+INDEX_BITS-1:0] line_addr;
    } l2_req_t;

    typedef struct packed {
        logic                 valid;
        logic [LINE_BITS-1:0] line;
    } l2_rsp_t;

    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [1:0]  addr;
        logic [31:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } csr_rsp_t;

endpackage
